// ==== Makefile ====
SHELL := /bin/bash

VERILATOR ?= verilator
TOP ?= tb_rvmini
BUILD_DIR ?= build
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

SRCS := $(filter %.sv %.v,$(shell cat src.f))
HDRS := $(wildcard *.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): src.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f src.f -Mdir $(BUILD_DIR)

run: $(BIN)
	set -o pipefail; $(BIN) 2>&1 | tee $(LOG)
	! grep -q "Finished with errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== core_ctrl.sv ====
`timescale 1ns/1ps

module core_ctrl (
  input logic clk,
  input logic reset,
  input logic run,
  input rvmini_pkg::decode_t dec,
  output rvmini_pkg::core_state_t state,
  output logic fetch_en,
  output logic commit,
  output logic retire,
  output logic halted,
  output logic trapped
);

  rvmini_pkg::core_state_t next_state;

  always_comb begin
    next_state = state;
    case (state)
      rvmini_pkg::IDLE: begin
        if (run) begin
          next_state = rvmini_pkg::FETCH;
        end
      end
      rvmini_pkg::FETCH: begin
        next_state = rvmini_pkg::EXEC;
      end
      rvmini_pkg::EXEC: begin
        // unknown word stops before any side effect
        if (dec.inst_not_ipl) begin
          next_state = rvmini_pkg::TRAP;
        end else if (dec.is_ebreak) begin
          next_state = rvmini_pkg::HALT;
        end else begin
          next_state = rvmini_pkg::FETCH;
        end
      end
      // halt and trap only leave on reset
      default: begin
        next_state = state;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rvmini_pkg::IDLE;
      halted <= 1'b0;
      trapped <= 1'b0;
    end else begin
      state <= next_state;
      // sticky status levels
      if (next_state == rvmini_pkg::HALT) begin
        halted <= 1'b1;
      end
      if (next_state == rvmini_pkg::TRAP) begin
        trapped <= 1'b1;
      end
    end
  end

  assign fetch_en = (state == rvmini_pkg::FETCH);
  // ebreak commits too
  assign commit = (state == rvmini_pkg::EXEC) && !dec.inst_not_ipl;
  assign retire = commit;

endmodule

// ==== decoder.sv ====
`timescale 1ns/1ps
`include "rvmini_defs.svh"

module decoder (
  input rvmini_pkg::inst_t inst,
  output rvmini_pkg::decode_t dec
);

  // opcode class
  logic op_imm;
  logic op_auipc;
  logic op_jal;
  logic op_store;
  logic op_system;

  // instruction hits
  logic nop;
  logic addi;
  logic auipc;
  logic jal;
  logic sd;
  logic ebreak;

  // per-format immediates
  rvmini_pkg::xword_t imm_i;
  rvmini_pkg::xword_t imm_u;
  rvmini_pkg::xword_t imm_j;
  rvmini_pkg::xword_t imm_s;

  assign op_imm = (inst[6:0] == `OP_IMM);
  assign op_auipc = (inst[6:0] == `AUIPC);
  assign op_jal = (inst[6:0] == `JAL);
  assign op_store = (inst[6:0] == `STORE);
  assign op_system = (inst[6:0] == `SYSTEM);

  // all-zero word is treated as a harmless nop
  assign nop = (inst == '0);
  assign addi = op_imm && (inst[14:12] == `FUNCT3_ADDI);
  assign auipc = op_auipc;
  assign jal = op_jal;
  assign sd = op_store && (inst[14:12] == `FUNCT3_SD);
  assign ebreak = op_system && (inst[14:12] == 3'b000) &&
                  (inst[31:20] == `FUNCT12_EBREAK);

  // sign extension from inst[31] in every format
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};

  always_comb begin
    dec = '0;
    // register fields sit at fixed positions
    dec.rd = inst[11:7];
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];

    // format picks the immediate
    if (addi) begin
      dec.imm = imm_i;
    end else if (auipc) begin
      dec.imm = imm_u;
    end else if (jal) begin
      dec.imm = imm_j;
    end else if (sd) begin
      dec.imm = imm_s;
    end

    // adder takes imm as second operand
    dec.need_imm = addi || auipc || sd;
    dec.alu_add = addi || auipc || sd;
    dec.is_auipc = auipc;
    dec.is_jal = jal;
    dec.is_ebreak = ebreak;

    // jal writes the link register
    dec.reg_wen = addi || auipc || jal;
    dec.mem_wen = sd;
    // sd is a full doubleword
    dec.wmask = sd ? 8'hff : 8'h00;

    dec.inst_not_ipl = !(addi || auipc || jal || sd || ebreak || nop);
  end

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
  input rvmini_pkg::decode_t dec,
  input rvmini_pkg::xword_t pc,
  input rvmini_pkg::xword_t rdata1,
  input rvmini_pkg::xword_t rdata2,
  input logic commit,
  output rvmini_pkg::xword_t wdata,
  output rvmini_pkg::xword_t jump_target,
  output rvmini_pkg::store_req_t store
);

  rvmini_pkg::xword_t op_a;
  rvmini_pkg::xword_t op_b;
  rvmini_pkg::xword_t sum;
  rvmini_pkg::xword_t alu_res;

  // auipc adds to pc, everything else to rs1
  assign op_a = dec.is_auipc ? pc : rdata1;
  assign op_b = dec.need_imm ? dec.imm : rdata2;
  assign sum = op_a + op_b;
  assign alu_res = dec.alu_add ? sum : '0;

  // jal links pc + 4
  assign wdata = dec.is_jal ? (pc + 'd4) : alu_res;
  assign jump_target = pc + dec.imm;

  // strobe only in the committing exec cycle
  assign store.valid = commit && dec.mem_wen;
  assign store.addr = sum;
  assign store.data = rdata2;
  assign store.wmask = dec.wmask;

endmodule

// ==== instr_mem.sv ====
`timescale 1ns/1ps
`include "rvmini_defs.svh"

module instr_mem (
  input logic clk,
  input logic load_en,
  input logic [`IMEM_AW-1:0] load_addr,
  input rvmini_pkg::inst_t load_data,
  input logic fetch_en,
  input logic [`IMEM_AW-1:0] fetch_addr,
  output rvmini_pkg::inst_t inst
);

  rvmini_pkg::inst_t mem [0:`IMEM_DEPTH-1];

  // program load, only while the core sits idle
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // registered read, inst holds until the next fetch
  always_ff @(posedge clk) begin
    if (fetch_en) begin
      inst <= mem[fetch_addr];
    end
  end

endmodule

// ==== pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit (
  input logic clk,
  input logic reset,
  input logic commit,
  input logic retire,
  input logic take_jump,
  input rvmini_pkg::xword_t jump_target,
  output rvmini_pkg::xword_t pc,
  output logic [31:0] retired
);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      retired <= '0;
    end else if (commit) begin
      // jal redirects, all else falls through
      if (take_jump) begin
        pc <= jump_target;
      end else begin
        pc <= pc + 'd4;
      end
      // trapped words never get here
      if (retire) begin
        retired <= retired + 32'd1;
      end
    end
  end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps
`include "rvmini_defs.svh"

module regfile (
  input logic clk,
  input rvmini_pkg::reg_id_t rs1,
  input rvmini_pkg::reg_id_t rs2,
  input rvmini_pkg::reg_id_t rd,
  input logic wen,
  input rvmini_pkg::xword_t wdata,
  output rvmini_pkg::xword_t rdata1,
  output rvmini_pkg::xword_t rdata2
);

  // entry 0 is never written
  rvmini_pkg::xword_t regs [0:(2**`REG_ID_W)-1];

  always_ff @(posedge clk) begin
    // writes to x0 are dropped
    if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // async read, x0 forced to zero
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rvmini_defs.svh ====
`ifndef RVMINI_DEFS_SVH
`define RVMINI_DEFS_SVH

// datapath widths
`define XLEN 64
`define INST_W 32
`define REG_ID_W 5

// instruction memory geometry, one word per entry
`define IMEM_DEPTH 256
`define IMEM_AW 8

// major opcodes, bits [6:0]
`define OP_IMM 7'b0010011
`define AUIPC 7'b0010111
`define JAL 7'b1101111
`define STORE 7'b0100011
`define SYSTEM 7'b1110011

// minor fields
`define FUNCT3_ADDI 3'b000
`define FUNCT3_SD 3'b011
`define FUNCT12_EBREAK 12'h001

`endif

// ==== rvmini_pkg.sv ====
`include "rvmini_defs.svh"

package rvmini_pkg;

  // raw words
  typedef logic [`INST_W-1:0] inst_t;
  typedef logic [`XLEN-1:0] xword_t;
  typedef logic [`REG_ID_W-1:0] reg_id_t;

  // decoder output, one bundle per instruction
  typedef struct packed {
    reg_id_t rd;
    reg_id_t rs1;
    reg_id_t rs2;
    // already sign extended
    xword_t imm;
    logic need_imm;
    logic alu_add;
    logic is_auipc;
    logic is_jal;
    logic is_ebreak;
    logic reg_wen;
    logic mem_wen;
    // one bit per byte lane
    logic [7:0] wmask;
    // word is not one of the supported instructions
    logic inst_not_ipl;
  } decode_t;

  // store strobe leaving the core
  typedef struct packed {
    logic valid;
    xword_t addr;
    xword_t data;
    logic [7:0] wmask;
  } store_req_t;

  // sequencer states
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    EXEC,
    HALT,
    TRAP
  } core_state_t;

endpackage

// ==== rvmini_top.sv ====
`timescale 1ns/1ps
`include "rvmini_defs.svh"

module rvmini_top (
  input logic clk,
  input logic reset,
  input logic run,
  input logic load_en,
  input logic [`IMEM_AW-1:0] load_addr,
  input rvmini_pkg::inst_t load_data,
  output rvmini_pkg::store_req_t store,
  output logic halted,
  output logic trapped,
  output logic [31:0] retired,
  output rvmini_pkg::xword_t pc
);

  rvmini_pkg::core_state_t state;
  rvmini_pkg::decode_t dec;
  rvmini_pkg::inst_t inst;
  rvmini_pkg::xword_t rdata1;
  rvmini_pkg::xword_t rdata2;
  rvmini_pkg::xword_t wdata;
  rvmini_pkg::xword_t jump_target;
  logic fetch_en;
  logic commit;
  logic retire;
  logic imem_load_en;
  logic rf_wen;

  // loads land only while idle
  assign imem_load_en = load_en && (state == rvmini_pkg::IDLE);
  // write back only on the committing cycle
  assign rf_wen = dec.reg_wen && commit;

  core_ctrl i_core_ctrl (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .dec      (dec),
    .state    (state),
    .fetch_en (fetch_en),
    .commit   (commit),
    .retire   (retire),
    .halted   (halted),
    .trapped  (trapped)
  );

  pc_unit i_pc_unit (
    .clk         (clk),
    .reset       (reset),
    .commit      (commit),
    .retire      (retire),
    .take_jump   (dec.is_jal),
    .jump_target (jump_target),
    .pc          (pc),
    .retired     (retired)
  );

  // word address from the byte pc
  instr_mem i_instr_mem (
    .clk        (clk),
    .load_en    (imem_load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .fetch_en   (fetch_en),
    .fetch_addr (pc[`IMEM_AW+1:2]),
    .inst       (inst)
  );

  decoder i_decoder (
    .inst (inst),
    .dec  (dec)
  );

  regfile i_regfile (
    .clk    (clk),
    .rs1    (dec.rs1),
    .rs2    (dec.rs2),
    .rd     (dec.rd),
    .wen    (rf_wen),
    .wdata  (wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  exec_unit i_exec_unit (
    .dec         (dec),
    .pc          (pc),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .commit      (commit),
    .wdata       (wdata),
    .jump_target (jump_target),
    .store       (store)
  );

endmodule

// ==== src.f ====
+incdir+.
rvmini_pkg.sv
decoder.sv
regfile.sv
instr_mem.sv
exec_unit.sv
pc_unit.sv
core_ctrl.sv
rvmini_top.sv
tb_rvmini.sv

// ==== tb_rvmini.sv ====
`timescale 1ns/1ps
`include "rvmini_defs.svh"

module tb_rvmini;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 10;
  localparam int N_TESTS = 16;
  // upper bound on executed instructions per program
  localparam int MAX_STEPS = 128;
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  logic clk;
  logic reset;
  logic run;
  logic load_en;
  logic [`IMEM_AW-1:0] load_addr;
  rvmini_pkg::inst_t load_data;
  rvmini_pkg::store_req_t store;
  logic halted;
  logic trapped;
  logic [31:0] retired;
  rvmini_pkg::xword_t pc;

  // program image, model state and expected results
  rvmini_pkg::inst_t prog [0:`IMEM_DEPTH-1];
  rvmini_pkg::store_req_t exp_q [$];
  rvmini_pkg::xword_t exp_pc;
  logic [31:0] exp_retired;
  logic [31:0] lcg_state;
  string cur_name;
  int errors;
  int tests;
  int t;

  rvmini_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .store     (store),
    .halted    (halted),
    .trapped   (trapped),
    .retired   (retired),
    .pc        (pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // instruction encoders, straight from the ISA formats
  function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'h13};
  endfunction

  function automatic logic [31:0] enc_auipc(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'h17};
  endfunction

  function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] enc_sd(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b011, off[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // unused words hold unimplemented opcode 7f, tagged by address
  task automatic clear_program();
    int a;
    for (a = 0; a < `IMEM_DEPTH; a++) begin
      prog[a] = {8'hee, 8'(a), 9'h1ab, 7'h7f};
    end
  endtask

  // executes prog by the ISA rules, fills exp_q, exp_pc, exp_retired
  // returns 1 when the program ends in ebreak, 0 on an unimplemented word
  function automatic bit run_model();
    rvmini_pkg::xword_t x [0:31];
    rvmini_pkg::xword_t mpc;
    rvmini_pkg::inst_t w;
    rvmini_pkg::store_req_t st;
    int steps;
    int i;
    bit done;
    bit halt;
    for (i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    mpc = '0;
    exp_retired = '0;
    exp_q.delete();
    done = 1'b0;
    halt = 1'b0;
    steps = 0;
    while (!done && steps < MAX_STEPS) begin
      w = prog[mpc[`IMEM_AW+1:2]];
      steps++;
      if (w == 32'h0) begin
        mpc = mpc + 64'd4;
        exp_retired++;
      end else if (w[6:0] == 7'h13 && w[14:12] == 3'b000) begin
        x[w[11:7]] = x[w[19:15]] + {{52{w[31]}}, w[31:20]};
        mpc = mpc + 64'd4;
        exp_retired++;
      end else if (w[6:0] == 7'h17) begin
        x[w[11:7]] = mpc + {{32{w[31]}}, w[31:12], 12'h000};
        mpc = mpc + 64'd4;
        exp_retired++;
      end else if (w[6:0] == 7'h6f) begin
        x[w[11:7]] = mpc + 64'd4;
        mpc = mpc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        exp_retired++;
      end else if (w[6:0] == 7'h23 && w[14:12] == 3'b011) begin
        st.valid = 1'b1;
        st.addr = x[w[19:15]] + {{52{w[31]}}, w[31:25], w[11:7]};
        st.data = x[w[24:20]];
        st.wmask = 8'hff;
        exp_q.push_back(st);
        mpc = mpc + 64'd4;
        exp_retired++;
      end else if (w[6:0] == 7'h73 && w[14:12] == 3'b000 && w[31:20] == 12'h001) begin
        // ebreak retires and steps past itself
        mpc = mpc + 64'd4;
        exp_retired++;
        done = 1'b1;
        halt = 1'b1;
      end else begin
        done = 1'b1;
      end
      x[0] = '0;
    end
    exp_pc = mpc;
    return halt;
  endfunction

  task automatic check_store(input string name, input rvmini_pkg::store_req_t exp,
                             input rvmini_pkg::store_req_t act);
    if (act !== exp) begin
      $display("** Error %s store: expected %0b/%h/%h/%h, actual %0b/%h/%h/%h", name,
               exp.valid, exp.addr, exp.data, exp.wmask,
               act.valid, act.addr, act.data, act.wmask);
      errors++;
    end
  endtask

  task automatic check_xword(input string name, input rvmini_pkg::xword_t exp,
                             input rvmini_pkg::xword_t act);
    if (act !== exp) begin
      $display("** Error %s pc: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s retired: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  // compare every strobe in order against the model's list
  always @(negedge clk) begin
    if (!reset && store.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("%s: store to %h seen but no store was expected", cur_name, store.addr);
        errors++;
      end else begin
        check_store(cur_name, exp_q.pop_front(), store);
      end
    end
  end

  task automatic load_program();
    int a;
    for (a = 0; a < `IMEM_DEPTH; a++) begin
      load_en = 1'b1;
      load_addr = 8'(a);
      load_data = prog[a];
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
  endtask

  task automatic run_test(input string name);
    int err_before;
    bit exp_halt;
    err_before = errors;
    cur_name = name;
    exp_halt = run_model();
    @(posedge clk);
    #1;
    reset = 1'b1;
    run = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    load_program();
    run = 1'b1;
    // watchdog covers a core that never stops
    while (!(halted || trapped)) begin
      @(posedge clk);
      #1;
    end
    run = 1'b0;
    if (exp_q.size() != 0) begin
      $display("%s: %0d expected stores never appeared", name, exp_q.size());
      errors++;
    end
    check_xword(name, exp_pc, pc);
    check_count(name, exp_retired, retired);
    check_flag({name, " halted"}, exp_halt, halted);
    check_flag({name, " trapped"}, !exp_halt, trapped);
    tests++;
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  // random mix of addi, auipc, sd and forward jal, ended by ebreak or a bad word
  task automatic gen_program();
    logic [31:0] r;
    int idx;
    int n;
    int k;
    int skip;
    clear_program();
    idx = 0;
    // x1..x7 get values before anything reads them
    for (k = 1; k < 8; k++) begin
      r = lcg_next();
      prog[idx] = enc_addi(5'(k), 5'd0, r[27:16]);
      idx++;
    end
    r = lcg_next();
    n = 8 + int'(r[31:28]) % 13;
    for (k = 0; k < n; k++) begin
      r = lcg_next();
      case (r[31:30])
        2'd0: prog[idx] = enc_addi({2'b0, r[29:27]}, {2'b0, r[26:24]}, r[20:9]);
        2'd1: prog[idx] = enc_auipc({2'b0, r[29:27]}, r[20:1]);
        2'd2: prog[idx] = enc_sd({2'b0, r[26:24]}, {2'b0, r[23:21]}, r[20:9]);
        default: begin
          // skipped words keep their fill pattern
          skip = 1 + int'(r[17:16]) % 3;
          prog[idx] = enc_jal({2'b0, r[29:27]}, 21'((skip + 1) * 4));
          idx += skip;
        end
      endcase
      idx++;
    end
    r = lcg_next();
    if (r[31:30] == 2'd0) begin
      prog[idx] = {r[29:5], 7'h0b};
    end else begin
      prog[idx] = EBREAK;
    end
  endtask

  initial begin
    reset = 1'b1;
    run = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    errors = 0;
    tests = 0;
    lcg_state = 32'd81091;

    // addi chain feeding two stores
    clear_program();
    prog[0] = enc_addi(5'd1, 5'd0, 12'd100);
    prog[1] = enc_addi(5'd2, 5'd0, 12'hffb);
    prog[2] = enc_sd(5'd1, 5'd2, 12'd8);
    prog[3] = enc_addi(5'd1, 5'd1, 12'd16);
    prog[4] = enc_sd(5'd1, 5'd1, 12'hff8);
    prog[5] = EBREAK;
    run_test("addi_sd");

    // auipc with positive and negative upper immediates
    clear_program();
    prog[0] = 32'h0;
    prog[1] = enc_auipc(5'd3, 20'h12345);
    prog[2] = enc_sd(5'd3, 5'd3, 12'h010);
    prog[3] = enc_auipc(5'd4, 20'hfffff);
    prog[4] = enc_sd(5'd0, 5'd4, 12'd8);
    prog[5] = EBREAK;
    run_test("auipc");

    // jal over two unimplemented words
    clear_program();
    prog[0] = enc_jal(5'd5, 21'd12);
    prog[3] = enc_sd(5'd0, 5'd5, 12'h040);
    prog[4] = EBREAK;
    run_test("jal");

    // writes to x0 vanish, nops retire
    clear_program();
    prog[0] = enc_addi(5'd0, 5'd0, 12'd55);
    prog[1] = enc_sd(5'd0, 5'd0, 12'h020);
    prog[2] = 32'h0;
    prog[3] = 32'h0;
    prog[4] = EBREAK;
    run_test("x0_nop");

    clear_program();
    prog[0] = enc_addi(5'd1, 5'd0, 12'd1);
    prog[1] = 32'h0;
    prog[2] = EBREAK;
    run_test("ebreak");

    // trap stops before the ebreak behind it
    clear_program();
    prog[0] = enc_addi(5'd1, 5'd0, 12'd7);
    prog[1] = enc_sd(5'd0, 5'd1, 12'd0);
    prog[2] = 32'hffff_ffff;
    prog[3] = EBREAK;
    run_test("trap");

    for (t = 0; t < 10; t++) begin
      gen_program();
      run_test($sformatf("random_%0d", t));
    end

    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // reset, full load and the longest program for every test
  initial begin
    #(N_TESTS * (RESET_CYCLES + `IMEM_DEPTH + 2 * MAX_STEPS + 16) * CLK_PERIOD);
    $display("watchdog: core did not halt or trap in time");
    $display("Finished with errors");
    $finish;
  end

endmodule
